//--- logic/jsp_tap_pkg.sv
// JSP TAP side definitions

package jsp_tap_pkg;

  //////////////////////////////////////////////////////////////////////
  // TAP strobes
  //////////////////////////////////////////////////////////////////////

  // Decoded DR strobes from the TAP controller, all in the tck domain
  typedef struct packed {
    logic capture;  // CAPTURE_DR
    logic shift;    // SHIFT_DR, low acts as PAUSE
    logic update;   // UPDATE_DR, ends the transfer
    logic select;   // This module is selected in the debug chain
  } jsp_tap_t;

  //////////////////////////////////////////////////////////////////////
  // Bit counting
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned BIT_CNT_W = 3;  // Counts 0..7 within a byte

  // Count value seen on the eighth shift of a byte
  localparam logic [BIT_CNT_W-1:0] BYTE_LAST_BIT = BIT_CNT_W'(7);

  //////////////////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////////////////

  // Write side, PC to receive FIFO
  typedef enum logic [1:0] {
    WR_IDLE   = 2'd0,  // Waiting for capture
    WR_WAIT   = 2'd1,  // Looking for the start bit
    WR_COUNTS = 2'd2,  // Count byte coming in
    WR_XFER   = 2'd3   // Data bytes
  } wr_state_e;

  // Read side, transmit FIFO to PC
  typedef enum logic [1:0] {
    RD_IDLE   = 2'd0,  // Waiting for capture
    RD_COUNTS = 2'd1,  // Status byte going out
    RD_RDACK  = 2'd2,  // First bit of a data byte, pops the FIFO
    RD_XFER   = 2'd3   // Rest of the data byte
  } rd_state_e;

endpackage

//--- logic/jsp_fifo_pkg.sv
// JSP byte FIFO definitions

package jsp_fifo_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned FIFO_DEPTH = 8;  // Entries per direction
  localparam int unsigned PTR_W      = 3;  // Read and write pointers
  localparam int unsigned CNT_W      = 4;  // Occupancy, holds 0..8

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [7:0]       jsp_byte_t;  // One UART style data byte
  typedef logic [CNT_W-1:0] jsp_cnt_t;   // Space, fill and word counters

  // Status nibbles as they go out in the status byte
  // tx_fill is the high nibble, rx_space the low one
  typedef struct packed {
    jsp_cnt_t tx_fill;   // Bytes waiting for the PC
    jsp_cnt_t rx_space;  // Free entries for bytes from the PC
  } fifo_status_t;

endpackage

//--- logic/jsp_write_ctrl.sv
// JSP write control stage

module jsp_write_ctrl
  import jsp_tap_pkg::*;
  import jsp_fifo_pkg::*;
(
  input  logic      tck_i,
  input  logic      rst_i,
  input  logic      tdi_i,
  input  jsp_tap_t  tap_i,       // TAP strobes
  input  jsp_cnt_t  rx_space_i,  // Receive FIFO free space
  output logic      rx_push_o,   // Store rx_byte_o this edge
  output jsp_byte_t rx_byte_o
);

  wr_state_e            state_q;
  wr_state_e            state_d;
  logic [BIT_CNT_W-1:0] bit_cnt_q;   // Bits of the current byte
  jsp_cnt_t             in_cnt_q;    // Space left, sampled at capture
  jsp_cnt_t             user_cnt_q;  // Bytes the PC still intends to send
  jsp_byte_t            shift_q;     // Bits shifted in so far
  logic                 start_xfer;
  logic                 byte_end;
  logic                 in_byte;

  assign start_xfer = tap_i.capture & tap_i.select;
  assign byte_end   = tap_i.shift & (bit_cnt_q == BYTE_LAST_BIT);
  assign in_byte    = (state_q == WR_COUNTS) || (state_q == WR_XFER);

  // Current tdi_i completes the byte as its MSB
  assign rx_byte_o = {tdi_i, shift_q[7:1]};

  // Push only while both budgets last, extra bytes just fall off
  assign rx_push_o = (state_q == WR_XFER) && byte_end &&
                     (in_cnt_q != '0) && (user_cnt_q != '0);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      WR_IDLE: begin
        if (start_xfer) begin
          state_d = WR_WAIT;
        end
      end
      WR_WAIT: begin
        // Zeros ahead of us belong to other devices in the chain
        if (tap_i.select && tap_i.shift && tdi_i) begin
          state_d = WR_COUNTS;
        end
      end
      WR_COUNTS: begin
        if (byte_end) begin
          state_d = WR_XFER;
        end
      end
      WR_XFER: begin
        state_d = WR_XFER;  // Stays until update
      end
      default: begin
        state_d = WR_IDLE;
      end
    endcase
    if (tap_i.update) begin
      state_d = WR_IDLE;  // Update always ends the transfer
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q  <= '0;
      in_cnt_q   <= '0;
      user_cnt_q <= '0;
    end else begin
      if ((state_q == WR_IDLE) && start_xfer) begin
        bit_cnt_q <= '0;
        in_cnt_q  <= rx_space_i;  // Space snapshot for this scan
      end else if (in_byte && tap_i.shift) begin
        bit_cnt_q <= bit_cnt_q + BIT_CNT_W'(1);  // Wraps to 0 after bit 7
      end
      if (rx_push_o) begin
        in_cnt_q <= in_cnt_q - CNT_W'(1);
      end
      // Upper nibble of the count byte
      if ((state_q == WR_COUNTS) && byte_end) begin
        user_cnt_q <= rx_byte_o[7:4];
      end else if (rx_push_o) begin
        user_cnt_q <= user_cnt_q - CNT_W'(1);
      end
    end
  end

  // Byte shift register, LSB arrives first
  always_ff @(posedge tck_i) begin
    if (tap_i.shift) begin
      shift_q <= rx_byte_o;
    end
  end

  // Snapshot never promises more room than the FIFO really has
  a_push_has_space : assert property (@(posedge tck_i) disable iff (rst_i)
    rx_push_o |-> (in_cnt_q <= rx_space_i));

endmodule

//--- logic/jsp_read_ctrl.sv
// JSP read control stage

module jsp_read_ctrl
  import jsp_tap_pkg::*;
  import jsp_fifo_pkg::*;
(
  input  logic         tck_i,
  input  logic         rst_i,
  input  jsp_tap_t     tap_i,      // TAP strobes
  input  fifo_status_t status_i,   // Space and fill from the FIFOs
  input  jsp_byte_t    tx_head_i,  // Transmit FIFO head, zero when empty
  output logic         tx_pop_o,   // One cycle pop strobe
  output logic         tdo_o
);

  rd_state_e            state_q;
  rd_state_e            state_d;
  logic [BIT_CNT_W-1:0] bit_cnt_q;  // Bits of the current byte
  jsp_cnt_t             out_cnt_q;  // Bytes left to send
  jsp_byte_t            shift_q;    // Parallel load, shift right
  logic                 start_xfer;
  logic                 byte_end;
  logic                 more_data;
  logic                 load_head;

  assign start_xfer = tap_i.capture & tap_i.select;
  assign byte_end   = tap_i.shift & (bit_cnt_q == BYTE_LAST_BIT);
  assign more_data  = (out_cnt_q != '0);

  // Next byte is latched at each byte end, acked one shift later
  assign load_head = byte_end && more_data &&
                     ((state_q == RD_COUNTS) || (state_q == RD_XFER));
  assign tx_pop_o  = (state_q == RD_RDACK) && tap_i.shift && more_data;

  assign tdo_o = shift_q[0];  // LSB first

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RD_IDLE: begin
        if (start_xfer) begin
          state_d = RD_COUNTS;
        end
      end
      RD_COUNTS: begin
        if (byte_end) begin
          state_d = RD_RDACK;
        end
      end
      RD_RDACK: begin
        if (tap_i.shift) begin
          state_d = RD_XFER;  // Held through PAUSE
        end
      end
      RD_XFER: begin
        if (byte_end) begin
          state_d = RD_RDACK;
        end
      end
      default: begin
        state_d = RD_IDLE;
      end
    endcase
    if (tap_i.update) begin
      state_d = RD_IDLE;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counters and tdo shift register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
      out_cnt_q <= '0;
      shift_q   <= '0;  // Keeps tdo_o low out of reset
    end else begin
      if ((state_q == RD_IDLE) && start_xfer) begin
        bit_cnt_q <= '0;
        out_cnt_q <= status_i.tx_fill;
        // Status byte goes out first
        shift_q   <= {status_i.tx_fill, status_i.rx_space};
      end else begin
        if ((state_q != RD_IDLE) && tap_i.shift) begin
          bit_cnt_q <= bit_cnt_q + BIT_CNT_W'(1);
        end
        if (load_head) begin
          shift_q <= tx_head_i;
        end else if ((state_q != RD_IDLE) && tap_i.shift) begin
          shift_q <= {1'b0, shift_q[7:1]};  // Zero fill behind the data
        end
        // Previous byte is done, it was popped in RD_RDACK
        if (load_head && (state_q == RD_XFER)) begin
          out_cnt_q <= out_cnt_q - CNT_W'(1);
        end
      end
    end
  end

  // Capture snapshot never runs ahead of the FIFO contents
  a_pop_has_data : assert property (@(posedge tck_i) disable iff (rst_i)
    tx_pop_o |-> (out_cnt_q <= status_i.tx_fill));

endmodule

//--- logic/jsp_byte_fifos.sv
// JSP receive and transmit byte FIFOs

module jsp_byte_fifos
  import jsp_fifo_pkg::*;
(
  input  logic         tck_i,
  input  logic         rst_i,
  input  logic         rx_push_i,        // From the write stage
  input  jsp_byte_t    rx_byte_i,
  input  logic         host_rx_pop_i,
  input  logic         host_tx_push_i,
  input  jsp_byte_t    host_tx_data_i,
  input  logic         tx_pop_i,         // From the read stage
  output jsp_byte_t    host_rx_data_o,   // Fall-through head
  output logic         host_rx_valid_o,
  output logic         host_tx_full_o,
  output jsp_byte_t    tx_head_o,
  output fifo_status_t status_o
);

  // Index 0 is the receive FIFO, index 1 the transmit FIFO
  logic      [1:0] push_w;
  logic      [1:0] pop_w;
  jsp_byte_t [1:0] wdata_w;
  jsp_byte_t [1:0] head_w;
  jsp_cnt_t  [1:0] fill_w;

  assign push_w  = {host_tx_push_i, rx_push_i};
  assign pop_w   = {tx_pop_i, host_rx_pop_i};
  assign wdata_w = {host_tx_data_i, rx_byte_i};

  //////////////////////////////////////////////////////////////////////
  // Circular buffers
  //////////////////////////////////////////////////////////////////////

  for (genvar f = 0; f < 2; f++) begin : g_fifo
    jsp_byte_t        mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    jsp_cnt_t         cnt_q;     // Occupancy 0..8
    logic             do_push;
    logic             do_pop;

    // Full push and empty pop are dropped
    assign do_push = push_w[f] && (cnt_q != CNT_W'(FIFO_DEPTH));
    assign do_pop  = pop_w[f] && (cnt_q != '0);

    always_ff @(posedge tck_i or posedge rst_i) begin
      if (rst_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (do_push) begin
          wr_ptr_q <= wr_ptr_q + PTR_W'(1);  // Wraps at depth 8
        end
        if (do_pop) begin
          rd_ptr_q <= rd_ptr_q + PTR_W'(1);
        end
        if (do_push && !do_pop) begin
          cnt_q <= cnt_q + CNT_W'(1);
        end else if (do_pop && !do_push) begin
          cnt_q <= cnt_q - CNT_W'(1);
        end
      end
    end

    // Storage
    always_ff @(posedge tck_i) begin
      if (do_push) begin
        mem_q[wr_ptr_q] <= wdata_w[f];
      end
    end

    assign head_w[f] = (cnt_q == '0) ? '0 : mem_q[rd_ptr_q];  // Zero when empty
    assign fill_w[f] = cnt_q;
  end

  //////////////////////////////////////////////////////////////////////
  // Host side and status
  //////////////////////////////////////////////////////////////////////

  assign host_rx_data_o  = head_w[0];
  assign host_rx_valid_o = (fill_w[0] != '0);
  assign host_tx_full_o  = (fill_w[1] == CNT_W'(FIFO_DEPTH));
  assign tx_head_o       = head_w[1];

  assign status_o = '{tx_fill: fill_w[1], rx_space: CNT_W'(FIFO_DEPTH) - fill_w[0]};

  // Write stage budget must keep it off a full receive FIFO
  a_rx_no_overflow : assert property (@(posedge tck_i) disable iff (rst_i)
    rx_push_i |-> (fill_w[0] != CNT_W'(FIFO_DEPTH)));

endmodule

//--- logic/jsp_top.sv
// JSP serial port top level

module jsp_top
  import jsp_tap_pkg::*;
  import jsp_fifo_pkg::*;
(
  input  logic      tck_i,
  input  logic      rst_i,
  input  logic      tdi_i,
  input  jsp_tap_t  tap_i,            // Capture, shift, update, select
  input  jsp_byte_t host_tx_data_i,
  input  logic      host_tx_push_i,
  input  logic      host_rx_pop_i,
  output logic      tdo_o,
  output jsp_byte_t host_rx_data_o,   // Head of the receive FIFO
  output logic      host_rx_valid_o,
  output logic      host_tx_full_o
);

  logic         rx_push;  // Write stage to receive FIFO
  jsp_byte_t    rx_byte;
  logic         tx_pop;   // Read stage acks the transmit head
  jsp_byte_t    tx_head;
  fifo_status_t status;   // Shared by both stages

  // PC to host direction
  jsp_write_ctrl u_write_ctrl (
    .tck_i     (tck_i),
    .rst_i     (rst_i),
    .tdi_i     (tdi_i),
    .tap_i     (tap_i),
    .rx_space_i(status.rx_space),
    .rx_push_o (rx_push),
    .rx_byte_o (rx_byte)
  );

  jsp_byte_fifos u_byte_fifos (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .rx_push_i      (rx_push),
    .rx_byte_i      (rx_byte),
    .host_rx_pop_i  (host_rx_pop_i),
    .host_tx_push_i (host_tx_push_i),
    .host_tx_data_i (host_tx_data_i),
    .tx_pop_i       (tx_pop),
    .host_rx_data_o (host_rx_data_o),
    .host_rx_valid_o(host_rx_valid_o),
    .host_tx_full_o (host_tx_full_o),
    .tx_head_o      (tx_head),
    .status_o       (status)
  );

  // Host to PC direction
  jsp_read_ctrl u_read_ctrl (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .tap_i    (tap_i),
    .status_i (status),
    .tx_head_i(tx_head),
    .tx_pop_o (tx_pop),
    .tdo_o    (tdo_o)
  );

endmodule

//--- dv/jsp_tb.sv
// JSP serial port testbench

module jsp_tb
  import jsp_tap_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  localparam int DEPTH      = 8;  // Entries in each FIFO
  localparam int NUM_TESTS  = 9;

  // One row of the stimulus table
  typedef struct {
    string name;
    int    tx_pushes;  // Host pushes ahead of the scan
    int    zeros;      // Garbage bits before the start bit
    int    user_cnt;   // Count nibble sent by the PC
    int    n_bytes;    // Full data bytes after the header or status byte
    int    tail_bits;  // Partial byte cut off by update
    int    rx_pops;    // Host pops after the scan
    bit    is_write;   // Write stream on tdi, else zeros
  } test_t;

  logic        tck;
  logic        rst;
  logic        tdi;
  jsp_tap_t    tap;
  logic [7:0]  host_tx_data;
  logic        host_tx_push;
  logic        host_rx_pop;
  logic        tdo;
  logic [7:0]  host_rx_data;
  logic        host_rx_valid;
  logic        host_tx_full;

  test_t       tests [NUM_TESTS];
  logic [7:0]  rx_model [$];  // PC to host bytes
  logic [7:0]  tx_model [$];  // Host to PC bytes
  logic [31:0] lcg_state = 32'h9496;
  string       cur_test;
  int          n_checks;
  int          n_errors;
  int          limit_cycles = 0;

  jsp_top i_dut (
    .tck_i          (tck),
    .rst_i          (rst),
    .tdi_i          (tdi),
    .tap_i          (tap),
    .host_tx_data_i (host_tx_data),
    .host_tx_push_i (host_tx_push),
    .host_rx_pop_i  (host_rx_pop),
    .tdo_o          (tdo),
    .host_rx_data_o (host_rx_data),
    .host_rx_valid_o(host_rx_valid),
    .host_tx_full_o (host_tx_full)
  );

  initial begin
    tck = 1'b0;
    forever #(CLK_PERIOD / 2) tck = ~tck;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Payload bytes, middle bits of the LCG state
  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Error: %s %s expected %0h actual %0h", cur_test, what, exp, act);
    end
  endtask

  // Shift cycles between capture and update
  function automatic int scan_len(input test_t t);
    if (t.is_write) begin
      return t.zeros + 9 + 8 * t.n_bytes + t.tail_bits;  // Start bit and count byte
    end
    return 8 * (t.n_bytes + 1) + t.tail_bits;  // Status byte first
  endfunction

  function automatic void build_table();
    //            name               push zero user byte tail pops write
    tests[0] = '{"reset_status",     0,   0,   0,   1,   0,   0,   1'b0};
    tests[1] = '{"read_three",       3,   0,   0,   4,   0,   0,   1'b0};
    tests[2] = '{"write_user_limit", 0,   0,   5,   6,   0,   0,   1'b1};
    tests[3] = '{"write_nearly_full", 0,  3,   15,  6,   0,   0,   1'b1};
    tests[4] = '{"read_rx_full",     2,   0,   0,   1,   0,   8,   1'b0};
    tests[5] = '{"write_cut_short",  0,   1,   4,   1,   5,   0,   1'b1};
    tests[6] = '{"write_after_cut",  0,   0,   3,   3,   0,   4,   1'b1};
    tests[7] = '{"tx_overfill",      9,   0,   0,   9,   0,   0,   1'b0};
    tests[8] = '{"read_empty",       0,   0,   0,   0,   0,   0,   1'b0};
  endfunction

  function automatic int watchdog_cycles();
    int total;
    total = 50;  // Reset and slack
    foreach (tests[i]) begin
      total += scan_len(tests[i]) + tests[i].tx_pushes + tests[i].rx_pops + 8;
    end
    return total;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////////////////////////

  task automatic host_push(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge tck);
      host_tx_push = 1'b1;
      host_tx_data = lcg_byte();
      if (tx_model.size() < DEPTH) begin
        tx_model.push_back(host_tx_data);  // Push to a full FIFO is lost
      end
    end
    @(negedge tck);
    host_tx_push = 1'b0;
    check("tx full flag", tx_model.size() == DEPTH, host_tx_full);
  endtask

  task automatic host_pop(input int n);
    logic [7:0] exp_b;
    for (int i = 0; i < n; i++) begin
      @(negedge tck);
      check("rx valid", rx_model.size() != 0, host_rx_valid);
      if (rx_model.size() != 0) begin
        exp_b = rx_model.pop_front();
        check($sformatf("rx byte %0d", i), exp_b, host_rx_data);  // Fall-through head
        host_rx_pop = 1'b1;
      end else begin
        host_rx_pop = 1'b0;
      end
    end
    @(negedge tck);
    host_rx_pop = 1'b0;
    check("rx valid at end", rx_model.size() != 0, host_rx_valid);
  endtask

  //////////////////////////////////////////////////////////////////////
  // JTAG scan: capture, shifts, update
  //////////////////////////////////////////////////////////////////////

  task automatic run_scan(input test_t t);
    logic       bits [$];
    logic [7:0] data [$];
    logic [7:0] tx_snap [$];
    logic [7:0] obs [];
    logic [7:0] status_exp;
    logic [7:0] exp_byte;
    logic [7:0] mask;
    logic [7:0] b;
    int         n_bits;
    int         space;
    int         n_push;
    int         n_pop;
    int         n_obs;

    if (t.is_write) begin
      repeat (t.zeros) bits.push_back(1'b0);
      bits.push_back(1'b1);  // Start bit
      b = {t.user_cnt[3:0], 4'h5};  // Low nibble carries no meaning
      for (int i = 0; i < 8; i++) bits.push_back(b[i]);
      for (int k = 0; k < t.n_bytes; k++) begin
        b = lcg_byte();
        data.push_back(b);
        for (int i = 0; i < 8; i++) bits.push_back(b[i]);  // LSB first
      end
      b = lcg_byte();
      for (int i = 0; i < t.tail_bits; i++) bits.push_back(b[i]);
    end else begin
      repeat (scan_len(t)) bits.push_back(1'b0);
    end
    n_bits = bits.size();
    n_obs  = (n_bits + 7) / 8;
    obs    = new[n_obs];

    // Snapshot at capture
    space      = DEPTH - rx_model.size();
    tx_snap    = tx_model;
    status_exp = {4'(tx_model.size()), 4'(space)};

    @(negedge tck);
    tap = '{capture: 1'b1, shift: 1'b0, update: 1'b0, select: 1'b1};
    for (int j = 0; j < n_bits; j++) begin
      @(negedge tck);
      obs[j / 8][j % 8] = tdo;  // Bit shown since the last rising edge
      tap = '{capture: 1'b0, shift: 1'b1, update: 1'b0, select: 1'b1};
      tdi = bits[j];
    end
    @(negedge tck);
    tap = '{capture: 1'b0, shift: 1'b0, update: 1'b1, select: 1'b1};
    tdi = 1'b0;
    @(negedge tck);
    tap = '0;

    // Status byte, then tx bytes up to the fill snapshot, then zeros
    for (int k = 0; k < n_obs; k++) begin
      mask = (k < n_bits / 8) ? 8'hff : 8'((1 << (n_bits % 8)) - 1);
      if (k == 0) begin
        exp_byte = status_exp;
      end else if (k <= tx_snap.size()) begin
        exp_byte = tx_snap[k - 1];
      end else begin
        exp_byte = 8'h00;
      end
      check($sformatf("tdo byte %0d", k), exp_byte & mask, obs[k] & mask);
    end

    // A byte is popped on the shift after its load
    n_pop = (n_bits - 1) / 8;
    if (n_pop > tx_snap.size()) n_pop = tx_snap.size();
    repeat (n_pop) void'(tx_model.pop_front());

    // Pushes end at the first used-up limit
    n_push = t.user_cnt;
    if (space < n_push) n_push = space;
    if (data.size() < n_push) n_push = data.size();
    for (int i = 0; i < n_push; i++) rx_model.push_back(data[i]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int errs_at_start;
    rst          = 1'b1;
    tdi          = 1'b0;
    tap          = '0;
    host_tx_data = '0;
    host_tx_push = 1'b0;
    host_rx_pop  = 1'b0;
    n_checks     = 0;
    n_errors     = 0;
    build_table();
    limit_cycles = watchdog_cycles();
    repeat (2) @(posedge tck);
    @(negedge tck);
    rst = 1'b0;

    cur_test = "after_reset";
    check("tdo", 1'b0, tdo);
    check("rx valid", 1'b0, host_rx_valid);

    foreach (tests[i]) begin
      cur_test      = tests[i].name;
      errs_at_start = n_errors;
      host_push(tests[i].tx_pushes);
      run_scan(tests[i]);
      host_pop(tests[i].rx_pops);
      $display("%-18s %s, %0d mismatches", cur_test,
               (n_errors == errs_at_start) ? "ok" : "bad", n_errors - errs_at_start);
    end

    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (limit_cycles > 0);
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish within %0d cycles", limit_cycles);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- tb.f
logic/jsp_tap_pkg.sv
logic/jsp_fifo_pkg.sv
logic/jsp_write_ctrl.sv
logic/jsp_read_ctrl.sv
logic/jsp_byte_fifos.sv
logic/jsp_top.sv
dv/jsp_tb.sv

//--- Bender.yml
package:
  name: jsp

sources:
  # Packages first
  - logic/jsp_tap_pkg.sv
  - logic/jsp_fifo_pkg.sv
  # Stages and top level
  - logic/jsp_write_ctrl.sv
  - logic/jsp_read_ctrl.sv
  - logic/jsp_byte_fifos.sv
  - logic/jsp_top.sv
  # Testbench
  - target: simulation
    files:
      - dv/jsp_tb.sv
